//--- compile.f
+incdir+hdl
hdl/ibuf_pkg.sv
hdl/bank_fifo.sv
hdl/multi_port_fifo.sv
hdl/fetch_packer.sv
hdl/decode_latch.sv
hdl/inst_buffer_top.sv
bench/tb_inst_buffer.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := tb_inst_buffer
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_inst_buffer.sv
`timescale 1ns/1ns
`include "ibuf_cfg.svh"

module tb_inst_buffer;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int T1_CYCLES    = 8;
  localparam int T2_CYCLES    = 200;
  localparam int FILL_LIMIT   = 40;
  localparam int HOLD_CYCLES  = 6;
  localparam int T4_CYCLES    = 400;
  localparam int T5_CYCLES    = 30;
  localparam int DRAIN_MAX    = 64;
  localparam int MARGIN       = 200;
  localparam int TOTAL_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + FILL_LIMIT +
                                HOLD_CYCLES + T4_CYCLES + 2 * T5_CYCLES + 1 + 5 * DRAIN_MAX;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + MARGIN) * CLK_PERIOD;
  // Packer register, FIFO and decode latch together
  localparam int FILL_CAP     = `IBUF_DEPTH + `IBUF_WPORTS + `IBUF_RPORTS;

  logic                               clk;
  logic                               rst_n;
  logic                               flush_i;
  ibuf_pkg::wlane_mask_t              fetch_valid_i;
  ibuf_pkg::inst_t [`IBUF_WPORTS-1:0] fetch_data_i;
  logic                               fetch_ready_o;
  ibuf_pkg::rlane_mask_t              dec_valid_o;
  ibuf_pkg::inst_t [`IBUF_RPORTS-1:0] dec_data_o;
  logic                               dec_ready_i;

  // Reference model state
  ibuf_pkg::inst_t                    ref_q [$];
  ibuf_pkg::inst_t [`IBUF_RPORTS-1:0] exp_data;
  int                                 exp_cnt;

  integer          seed;
  ibuf_pkg::inst_t seq;
  int              err_cnt;
  int              tests_run;
  int              errs;
  int              n;
  int              free_slots;

  inst_buffer_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_data_i  (fetch_data_i),
    .fetch_ready_o (fetch_ready_o),
    .dec_valid_o   (dec_valid_o),
    .dec_data_o    (dec_data_o),
    .dec_ready_i   (dec_ready_i)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==================================================
  // Reference model
  // ==================================================
  // Every accepted word not yet taken by decode in age order
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_q.delete();
      exp_data <= '0;
      exp_cnt  <= 0;
    end else begin
      if (flush_i) begin
        ref_q.delete();
      end else begin
        if (dec_ready_i) begin
          for (int k = 0; k < `IBUF_RPORTS; k++) begin
            if (dec_valid_o[k] && ref_q.size() > 0) begin
              void'(ref_q.pop_front());
            end
          end
        end
        if (fetch_ready_o) begin
          for (int i = 0; i < `IBUF_WPORTS; i++) begin
            if (fetch_valid_i[i]) begin
              ref_q.push_back(fetch_data_i[i]);
            end
          end
        end
      end
      for (int k = 0; k < `IBUF_RPORTS; k++) begin
        exp_data[k] <= (k < ref_q.size()) ? ref_q[k] : '0;
      end
      exp_cnt <= ref_q.size();
    end
  end

  // ==================================================
  // Checks on the decode side
  // ==================================================
  for (genvar k = 0; k < `IBUF_RPORTS; k++) begin : g_lane_chk
    a_dec_word: assert property (@(posedge clk) disable iff (!rst_n)
      (dec_valid_o[k] && dec_ready_i) |-> (dec_data_o[k] == exp_data[k]))
      else begin
        err_cnt++;
        $display("[FAIL] t=%0t dec_data_o[%0d] expected %h actual %h", $time, k,
                 $sampled(exp_data[k]), $sampled(dec_data_o[k]));
      end
  end

  a_dec_contig: assert property (@(posedge clk) disable iff (!rst_n)
    (dec_valid_o & (dec_valid_o + ibuf_pkg::rlane_mask_t'(1))) == '0)
    else begin
      err_cnt++;
      $display("[FAIL] t=%0t dec_valid_o expected contiguous mask actual %b",
               $time, $sampled(dec_valid_o));
    end

  // More valid lanes than words in flight means a duplicate
  a_dec_count: assert property (@(posedge clk) disable iff (!rst_n)
    $countones(dec_valid_o) <= exp_cnt)
    else begin
      err_cnt++;
      $display("[FAIL] t=%0t dec_valid_o expected at most %0d lanes actual %b",
               $time, $sampled(exp_cnt), $sampled(dec_valid_o));
    end

  a_dec_stall: assert property (@(posedge clk) disable iff (!rst_n)
    ((|dec_valid_o) && !dec_ready_i && !flush_i) |=>
      ($stable(dec_valid_o) && $stable(dec_data_o)))
    else begin
      err_cnt++;
      $display("[FAIL] t=%0t dec_valid_o expected %b held actual %b",
               $time, $past(dec_valid_o), $sampled(dec_valid_o));
    end

  // ==================================================
  // Stimulus helpers
  // ==================================================
  // One cycle of traffic entered and left 1 ns after a rising edge
  task automatic drive_cycle(input ibuf_pkg::wlane_mask_t mask, input logic rdy);
    ibuf_pkg::inst_t cnt;
    cnt = '0;
    fetch_valid_i = mask;
    dec_ready_i   = rdy;
    for (int i = 0; i < `IBUF_WPORTS; i++) begin
      if (mask[i]) begin
        fetch_data_i[i] = seq + cnt;
        cnt = cnt + ibuf_pkg::inst_t'(1);
      end else begin
        // Holes carry junk
        fetch_data_i[i] = ibuf_pkg::inst_t'($random(seed));
      end
    end
    @(posedge clk);
    if (fetch_ready_o && (|mask)) begin
      seq = seq + cnt;
    end
    #1;
  endtask

  task automatic expect_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    assert (actual === expected) else begin
      err_cnt++;
      $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic drain(input string what);
    int cyc;
    cyc = 0;
    while ((ref_q.size() != 0 || dec_valid_o != '0) && cyc < DRAIN_MAX) begin
      drive_cycle('0, 1'b1);
      cyc++;
    end
    assert (ref_q.size() == 0 && dec_valid_o == '0) else begin
      err_cnt++;
      $display("%s: buffer still held words after %0d drain cycles", what, DRAIN_MAX);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d check(s) failed", tests_run, name, err_cnt - errs_before);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    seed          = 1;
    seq           = '0;
    err_cnt       = 0;
    tests_run     = 0;
    rst_n         = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = '0;
    fetch_data_i  = '0;
    dec_ready_i   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset values and latency of one full group
    errs = err_cnt;
    expect_equal("dec_valid_o", dec_valid_o, '0);
    expect_equal("fetch_ready_o", fetch_ready_o, 1);
    drive_cycle('1, 1'b1);
    expect_equal("seq", seq, `IBUF_WPORTS);
    drive_cycle('0, 1'b1);
    expect_equal("dec_valid_o", dec_valid_o, '0);
    drive_cycle('0, 1'b1);
    expect_equal("dec_valid_o", dec_valid_o, {`IBUF_RPORTS{1'b1}});
    drain("reset and latency");
    report_test("reset and latency", errs);

    errs = err_cnt;
    repeat (T2_CYCLES) drive_cycle(ibuf_pkg::wlane_mask_t'($random(seed)), 1'b1);
    drain("holed fetch groups");
    report_test("holed fetch groups", errs);

    // Fill everything while decode stalls
    errs = err_cnt;
    n = 0;
    do begin
      drive_cycle('1, 1'b0);
      n++;
    end while (fetch_ready_o && n < FILL_LIMIT);
    assert (!fetch_ready_o) else begin
      err_cnt++;
      $display("back-pressure: fetch_ready_o stayed high for %0d stalled cycles", FILL_LIMIT);
    end
    free_slots = FILL_CAP - ref_q.size();
    assert (free_slots < `IBUF_WPORTS) else begin
      err_cnt++;
      $display("[FAIL] t=%0t free slots expected below %0d actual %0d",
               $time, `IBUF_WPORTS, free_slots);
    end
    repeat (HOLD_CYCLES) drive_cycle('1, 1'b0);
    drain("back-pressure");
    report_test("back-pressure", errs);

    errs = err_cnt;
    repeat (T4_CYCLES) begin
      drive_cycle(ibuf_pkg::wlane_mask_t'($random(seed)), 1'($random(seed)));
    end
    drain("random decode stalls");
    report_test("random decode stalls", errs);

    // Flush with traffic on both sides
    errs = err_cnt;
    repeat (T5_CYCLES) begin
      drive_cycle(ibuf_pkg::wlane_mask_t'($random(seed)), 1'($random(seed)));
    end
    flush_i = 1'b1;
    drive_cycle('1, 1'b1);
    flush_i = 1'b0;
    expect_equal("dec_valid_o", dec_valid_o, '0);
    repeat (T5_CYCLES) begin
      drive_cycle(ibuf_pkg::wlane_mask_t'($random(seed)), 1'($random(seed)));
    end
    drain("flush");
    report_test("flush", errs);

    $display("tests run %0d, checks failed %0d", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- hdl/inst_buffer_top.sv
`timescale 1ns/1ns
`include "ibuf_cfg.svh"

module inst_buffer_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush_i,
  input  ibuf_pkg::wlane_mask_t              fetch_valid_i,
  input  ibuf_pkg::inst_t [`IBUF_WPORTS-1:0] fetch_data_i,
  output logic                               fetch_ready_o,
  output ibuf_pkg::rlane_mask_t              dec_valid_o,
  output ibuf_pkg::inst_t [`IBUF_RPORTS-1:0] dec_data_o,
  input  logic                               dec_ready_i
);

  // Packer to FIFO
  ibuf_pkg::wlane_mask_t              pk_valid;
  ibuf_pkg::inst_t [`IBUF_WPORTS-1:0] pk_data;
  logic                               pk_ready;

  // FIFO to latch
  ibuf_pkg::rlane_mask_t              rd_valid;
  ibuf_pkg::rlane_mask_t              rd_ready;
  ibuf_pkg::inst_t [`IBUF_RPORTS-1:0] rd_data;

  fetch_packer packer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_data_i  (fetch_data_i),
    .fetch_ready_o (fetch_ready_o),
    .pk_valid_o    (pk_valid),
    .pk_data_o     (pk_data),
    .pk_ready_i    (pk_ready)
  );

  multi_port_fifo #(
    .DEPTH (`IBUF_DEPTH)
  ) fifo_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .write_valid_i (pk_valid),
    .write_ready_o (pk_ready),
    .write_data_i  (pk_data),
    .read_valid_o  (rd_valid),
    .read_ready_i  (rd_ready),
    .read_data_o   (rd_data)
  );

  decode_latch latch_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .rd_valid_i  (rd_valid),
    .rd_data_i   (rd_data),
    .rd_ready_o  (rd_ready),
    .dec_valid_o (dec_valid_o),
    .dec_data_o  (dec_data_o),
    .dec_ready_i (dec_ready_i)
  );

endmodule

//--- hdl/decode_latch.sv
`timescale 1ns/1ns
`include "ibuf_cfg.svh"

module decode_latch (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush_i,
  input  ibuf_pkg::rlane_mask_t              rd_valid_i,
  input  ibuf_pkg::inst_t [`IBUF_RPORTS-1:0] rd_data_i,
  output ibuf_pkg::rlane_mask_t              rd_ready_o,
  output ibuf_pkg::rlane_mask_t              dec_valid_o,
  output ibuf_pkg::inst_t [`IBUF_RPORTS-1:0] dec_data_o,
  input  logic                               dec_ready_i
);

  logic load_en;

  // Take everything offered, or nothing while decode stalls
  assign load_en    = (dec_valid_o == '0) | dec_ready_i;
  assign rd_ready_o = {`IBUF_RPORTS{load_en}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid_o <= '0;
    end else if (flush_i) begin
      dec_valid_o <= '0;
    end else if (load_en) begin
      dec_valid_o <= rd_valid_i;
    end
  end

  // Invalid lanes may carry stale words
  always_ff @(posedge clk) begin
    if (load_en) begin
      dec_data_o <= rd_data_i;
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ((|dec_valid_o) && !dec_ready_i && !flush_i) |=>
      ($stable(dec_valid_o) && $stable(dec_data_o)))
    else $error("decode_latch: group changed while stalled, valid=%b", dec_valid_o);

endmodule

//--- hdl/fetch_packer.sv
`timescale 1ns/1ns
`include "ibuf_cfg.svh"

module fetch_packer (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush_i,
  input  ibuf_pkg::wlane_mask_t              fetch_valid_i,
  input  ibuf_pkg::inst_t [`IBUF_WPORTS-1:0] fetch_data_i,
  output logic                               fetch_ready_o,
  output ibuf_pkg::wlane_mask_t              pk_valid_o,
  output ibuf_pkg::inst_t [`IBUF_WPORTS-1:0] pk_data_o,
  input  logic                               pk_ready_i
);

  ibuf_pkg::wlane_cnt_t               lane_cnt;
  ibuf_pkg::wlane_mask_t              packed_valid;
  ibuf_pkg::inst_t [`IBUF_WPORTS-1:0] packed_data;
  logic                               load_en;
  logic                               fetch_fire;

  // Compaction, each valid lane drops to the count of valid lanes below it
  always_comb begin
    lane_cnt    = '0;
    packed_data = '0;
    for (int i = 0; i < `IBUF_WPORTS; i++) begin
      if (fetch_valid_i[i]) begin
        packed_data[lane_cnt] = fetch_data_i[i];
        lane_cnt = lane_cnt + ibuf_pkg::wlane_cnt_t'(1);
      end
    end
    for (int i = 0; i < `IBUF_WPORTS; i++) begin
      packed_valid[i] = (ibuf_pkg::wlane_cnt_t'(i) < lane_cnt);
    end
  end

  // Register is free when empty or draining this cycle
  assign load_en       = (pk_valid_o == '0) | pk_ready_i;
  assign fetch_ready_o = load_en;
  assign fetch_fire    = load_en & (|fetch_valid_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pk_valid_o <= '0;
    end else if (flush_i) begin
      pk_valid_o <= '0;
    end else if (load_en) begin
      pk_valid_o <= packed_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_fire) begin
      pk_data_o <= packed_data;
    end
  end

  a_pk_contig: assert property (@(posedge clk) disable iff (!rst_n)
    (pk_valid_o & (pk_valid_o + ibuf_pkg::wlane_mask_t'(1))) == '0)
    else $error("fetch_packer: packed mask %b has a hole", pk_valid_o);

endmodule

//--- hdl/multi_port_fifo.sv
`timescale 1ns/1ns
`include "ibuf_cfg.svh"

module multi_port_fifo #(
  parameter int DEPTH = `IBUF_DEPTH
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  flush_i,
  input  ibuf_pkg::wlane_mask_t                 write_valid_i,
  output logic                                  write_ready_o,
  input  ibuf_pkg::inst_t [`IBUF_WPORTS-1:0]    write_data_i,
  output ibuf_pkg::rlane_mask_t                 read_valid_o,
  input  ibuf_pkg::rlane_mask_t                 read_ready_i,
  output ibuf_pkg::inst_t [`IBUF_RPORTS-1:0]    read_data_o
);

  localparam int BANKS = `IBUF_BANKS;
  // Compare width that holds any bank index and any lane count
  localparam int IW = $bits(ibuf_pkg::bank_ptr_t) + 1;
  localparam int FW = $clog2(BANKS + 1);
  localparam logic [FW-1:0] FULL_LIMIT = FW'(BANKS - `IBUF_WPORTS);

  ibuf_pkg::wlane_cnt_t          write_num;
  ibuf_pkg::rlane_cnt_t          read_num;
  logic                          write_fire;
  logic [FW-1:0]                 full_cnt;
  logic [BANKS-1:0]              bank_push;
  logic [BANKS-1:0]              bank_pop;
  logic [BANKS-1:0]              bank_empty;
  logic [BANKS-1:0]              bank_full;
  ibuf_pkg::inst_t [BANKS-1:0]   bank_dout;

  // ==================================================
  // Word counts and write admission
  // ==================================================
  always_comb begin
    write_num = '0;
    for (int k = 0; k < `IBUF_WPORTS; k++) begin
      write_num = write_num + ibuf_pkg::wlane_cnt_t'(write_valid_i[k]);
    end
    read_num = '0;
    for (int k = 0; k < `IBUF_RPORTS; k++) begin
      read_num = read_num + ibuf_pkg::rlane_cnt_t'(read_valid_o[k] & read_ready_i[k]);
    end
    full_cnt = '0;
    for (int b = 0; b < BANKS; b++) begin
      full_cnt = full_cnt + FW'(bank_full[b]);
    end
  end

  // Room for a whole group, whatever its size
  assign write_ready_o = (full_cnt <= FULL_LIMIT);
  assign write_fire    = (|write_valid_i) & write_ready_o;

  // ==================================================
  // Banks
  // ==================================================
  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    ibuf_pkg::bank_ptr_t wr_idx_q;
    ibuf_pkg::bank_ptr_t rd_idx_q;
    ibuf_pkg::inst_t     din;

    // Index is this bank's distance from the current head bank
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wr_idx_q <= ibuf_pkg::bank_ptr_t'(b);
        rd_idx_q <= ibuf_pkg::bank_ptr_t'(b);
      end else if (flush_i) begin
        wr_idx_q <= ibuf_pkg::bank_ptr_t'(b);
        rd_idx_q <= ibuf_pkg::bank_ptr_t'(b);
      end else begin
        if (write_fire) begin
          wr_idx_q <= wr_idx_q - ibuf_pkg::bank_ptr_t'(write_num);
        end
        rd_idx_q <= rd_idx_q - ibuf_pkg::bank_ptr_t'(read_num);
      end
    end

    assign bank_push[b] = write_fire & (IW'(wr_idx_q) < IW'(write_num));
    assign bank_pop[b]  = (IW'(rd_idx_q) < IW'(read_num));

    // Lane whose position matches this bank's index
    always_comb begin
      din = '0;
      for (int k = 0; k < `IBUF_WPORTS; k++) begin
        if (wr_idx_q == ibuf_pkg::bank_ptr_t'(k)) begin
          din = write_data_i[k];
        end
      end
    end

    bank_fifo #(
      .DEPTH (DEPTH / BANKS),
      .WIDTH ($bits(ibuf_pkg::inst_t))
    ) bank_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush_i (flush_i),
      .push_i  (bank_push[b]),
      .pop_i   (bank_pop[b]),
      .data_i  (din),
      .data_o  (bank_dout[b]),
      .empty_o (bank_empty[b]),
      .full_o  (bank_full[b])
    );
  end

  // ==================================================
  // Read lanes
  // ==================================================
  for (genvar k = 0; k < `IBUF_RPORTS; k++) begin : g_rd_lane
    ibuf_pkg::bank_ptr_t idx_q;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        idx_q <= ibuf_pkg::bank_ptr_t'(k);
      end else if (flush_i) begin
        idx_q <= ibuf_pkg::bank_ptr_t'(k);
      end else begin
        idx_q <= idx_q + ibuf_pkg::bank_ptr_t'(read_num);
      end
    end

    assign read_valid_o[k] = ~bank_empty[idx_q];
    assign read_data_o[k]  = bank_dout[idx_q];
  end

  a_write_contig: assert property (@(posedge clk) disable iff (!rst_n)
    (write_valid_i & (write_valid_i + ibuf_pkg::wlane_mask_t'(1))) == '0)
    else $error("multi_port_fifo: write mask %b not contiguous", write_valid_i);

  // Banks stay in word order, so the offered lanes never have a hole
  a_read_contig: assert property (@(posedge clk) disable iff (!rst_n)
    ((read_valid_o & (read_valid_o + ibuf_pkg::rlane_mask_t'(1))) == '0) &&
    ((read_ready_i & (read_ready_i + ibuf_pkg::rlane_mask_t'(1))) == '0))
    else $error("multi_port_fifo: read valid %b ready %b not contiguous",
                read_valid_o, read_ready_i);

endmodule

//--- hdl/bank_fifo.sv
`timescale 1ns/1ns
`include "ibuf_cfg.svh"

module bank_fifo #(
  parameter int DEPTH = `IBUF_DEPTH / `IBUF_BANKS,
  parameter int WIDTH = `IBUF_DATA_W
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr_q;
  logic [AW-1:0]    rd_ptr_q;
  logic [CW-1:0]    count_q;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    logic [AW-1:0] nxt;
    if (ptr == AW'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + AW'(1);
    end
    return nxt;
  endfunction

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      count_q <= count_q + CW'(push_i) - CW'(pop_i);
    end
  end

  // Head word straight out of the storage flops
  assign data_o  = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CW'(DEPTH));

  // Caller must respect the flags
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    !(push_i && full_o) && !(pop_i && empty_o))
    else $error("bank_fifo: push=%b full=%b pop=%b empty=%b",
                push_i, full_o, pop_i, empty_o);

endmodule

//--- hdl/ibuf_pkg.sv
`include "ibuf_cfg.svh"

package ibuf_pkg;

  // One instruction word
  typedef logic [`IBUF_DATA_W-1:0] inst_t;

  // Lane masks, bit 0 is the oldest word of a group
  typedef logic [`IBUF_WPORTS-1:0] wlane_mask_t;
  typedef logic [`IBUF_RPORTS-1:0] rlane_mask_t;

  // Lane counts, 0 up to the full group
  typedef logic [$clog2(`IBUF_WPORTS + 1)-1:0] wlane_cnt_t;
  typedef logic [$clog2(`IBUF_RPORTS + 1)-1:0] rlane_cnt_t;

  // Rotating bank index
  typedef logic [$clog2(`IBUF_BANKS)-1:0] bank_ptr_t;

endpackage

//--- hdl/ibuf_cfg.svh
`ifndef IBUF_CFG_SVH
`define IBUF_CFG_SVH

// ==================================================
// Instruction buffer sizing
// ==================================================

// Total entries, must divide evenly over the banks
`define IBUF_DEPTH 16

// One instruction word
`define IBUF_DATA_W 32

// Lanes per fetch group and per decode group
`define IBUF_WPORTS 4
`define IBUF_RPORTS 4

// One bank per lane on the wider side
`define IBUF_BANKS ((`IBUF_WPORTS > `IBUF_RPORTS) ? `IBUF_WPORTS : `IBUF_RPORTS)

`endif
